//--- all.f
arm_core_pkg.sv
arm_isa_pkg.sv
pipe_ifs.sv
instr_memory.sv
fetch_counter.sv
register_file.sv
decode_stage.sv
execute_stage.sv
arm_pipeline_top.sv
tb_arm_pipeline.sv

//--- tb_arm_pipeline.sv
// Testbench for the data-processing pipeline: reference model, assertions, random program
`timescale 1ns/1ns

module tb_arm_pipeline import arm_core_pkg::*, arm_isa_pkg::*; ();

  localparam int NUM_PROGS  = 5;
  localparam int MAX_CYCLES = 16 + NUM_PROGS * 80;

  typedef struct packed {
    reg_idx_t rd;
    word_t    data;
    flags_t   flags;
  } wb_rec_t;

  logic     clk;
  logic     reset;
  logic     prog_we;
  pc_t      prog_addr;
  word_t    prog_data;
  pc_t      pc;
  logic     wb_valid;
  reg_idx_t wb_rd;
  word_t    wb_data;
  flags_t   flags;

  wb_rec_t     exp_q[$];        // Expected write-backs in retire order
  instr_t      prog[$];
  word_t       model_regs [15];
  flags_t      model_flags;
  int          prev_len     = 0;  // Words written by the previous program
  int          run_edges    = 0;
  int          cycles       = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  logic [31:0] rng          = 32'd83;

  arm_pipeline_top #(.IMEM_BYTES(256)) uut (
    .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .pc(pc), .wb_valid(wb_valid), .wb_rd(wb_rd),
    .wb_data(wb_data), .flags(flags)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      run_edges <= 0;
    end else begin
      run_edges <= run_edges + 1;
    end
  end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic instr_t dp_imm(logic [3:0] op, logic s, reg_idx_t rn, reg_idx_t rd,
                                    logic [3:0] rot, logic [7:0] imm);
    return {4'hE, 3'b001, op, s, rn, rd, rot, imm};
  endfunction

  function automatic instr_t dp_reg(logic [3:0] op, logic s, reg_idx_t rn, reg_idx_t rd,
                                    logic [4:0] amt, logic [1:0] typ, reg_idx_t rm);
    return {4'hE, 3'b000, op, s, rn, rd, amt, typ, 1'b0, rm};
  endfunction

  function automatic word_t rotr(word_t v, int n);
    if (n == 0) begin
      return v;
    end
    return (v >> n) | (v << (32 - n));
  endfunction

  // R15 reads as the address of the next word
  function automatic word_t read_model(reg_idx_t idx, int addr);
    if (idx == 4'd15) begin
      return word_t'(pc_t'(addr + 4));
    end
    return model_regs[idx];
  endfunction

  task automatic check_value(string name, word_t expected, word_t actual);
    assert (expected === actual) else begin
      $display("FAILED t=%0t %s expected %h actual %h", $time, name, expected, actual);
      value_errors++;
    end
  endtask

  // Walks the program in address order and queues its write-backs
  task automatic predict();
    instr_t      w;
    reg_idx_t    rd;
    word_t       a;
    word_t       op2;
    word_t       res;
    logic [32:0] sum;
    logic        arith;
    logic        c;
    logic        v;
    logic        supported;
    wb_rec_t     rec;
    for (int k = 0; k < prog.size(); k++) begin
      w = prog[k];
      rd = w[15:12];
      case (w[24:21])
        4'b0000, 4'b0010, 4'b0100, 4'b1100, 4'b1101: supported = 1'b1;
        default: supported = 1'b0;
      endcase
      if (w == '0 || !supported || rd == 4'd15) begin
        continue;
      end
      if (w[25]) begin
        op2 = rotr({24'h0, w[7:0]}, 2 * int'(w[11:8]));
      end else begin
        case (w[6:5])
          2'd0:    op2 = read_model(w[3:0], k * 4) << w[11:7];
          2'd1:    op2 = read_model(w[3:0], k * 4) >> w[11:7];
          2'd2:    op2 = $signed(read_model(w[3:0], k * 4)) >>> w[11:7];
          default: op2 = rotr(read_model(w[3:0], k * 4), int'(w[11:7]));
        endcase
      end
      a = read_model(w[19:16], k * 4);
      arith = 1'b0;
      c = 1'b0;
      v = 1'b0;
      case (w[24:21])
        4'b0000: res = a & op2;
        4'b1100: res = a | op2;
        4'b0100: begin
          sum = 33'(a) + 33'(op2);
          res = sum[31:0];
          arith = 1'b1;
          c = sum[32];
          v = (a[31] == op2[31]) && (res[31] != a[31]);
        end
        4'b0010: begin
          res = a - op2;
          arith = 1'b1;
          c = (a >= op2);  // No borrow
          v = (a[31] != op2[31]) && (res[31] != a[31]);
        end
        default: res = op2;
      endcase
      if (w[20]) begin
        model_flags[3] = res[31];
        model_flags[2] = (res == '0);
        if (arith) begin
          model_flags[1] = c;
          model_flags[0] = v;
        end
      end
      model_regs[rd] = res;
      rec.rd = rd;
      rec.data = res;
      rec.flags = model_flags;
      exp_q.push_back(rec);
    end
  endtask

  // Loads under reset, clears leftovers of the last program, runs until drained
  task automatic run_program();
    int n_words;
    int n_reset;
    n_words = (prog.size() > prev_len) ? prog.size() : prev_len;
    n_reset = (n_words > 16) ? n_words : 16;
    reset = 1'b1;
    model_flags = '0;
    predict();
    for (int i = 0; i < n_reset; i++) begin
      prog_we = (i < n_words);
      prog_addr = pc_t'(i * 4);
      prog_data = (i < prog.size()) ? prog[i] : '0;
      @(posedge clk);
      #2;
    end
    prog_we = 1'b0;
    reset = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);  // Room for stray pulses
    #2;
    prev_len = prog.size();
    prog.delete();
  endtask

  always @(negedge clk) begin
    wb_rec_t head;
    if (reset) begin
      check_value("wb_valid", '0, wb_valid);
      check_value("flags", '0, flags);
    end
    check_value("pc", pc_t'(run_edges * 4), pc);
    if (!reset && wb_valid) begin
      assert (exp_q.size() != 0) else begin
        $display("Unexpected write-back to R%0d at t=%0t", wb_rd, $time);
        other_errors++;
      end
      if (exp_q.size() != 0) begin
        head = exp_q.pop_front();
        check_value("wb_rd", head.rd, wb_rd);
        check_value("wb_data", head.data, wb_data);
        check_value("flags", head.flags, flags);
      end
    end
  end

  initial begin
    wait (cycles >= MAX_CYCLES);
    $display("Timeout after %0d cycles with %0d write-backs still pending", cycles,
             exp_q.size());
    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    $display("test failed");
    $finish;
  end

  initial begin
    logic [3:0]  ops [5];
    int          amts [4];
    logic [31:0] r1;
    logic [31:0] r2;
    ops = '{OP_AND, OP_SUB, OP_ADD, OP_ORR, OP_MOV};
    amts = '{0, 1, 17, 31};
    reset = 1'b1;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    // Every general register gets a rotated immediate
    for (int r = 0; r < 15; r++) begin
      prog.push_back(dp_imm(OP_MOV, 1'b0, 4'd0, reg_idx_t'(r), 4'(r), 8'(r * 37 + 5)));
    end
    prog.push_back('0);
    prog.push_back(dp_imm(4'b0001, 1'b0, 4'd1, 4'd2, 4'd0, 8'h55));  // EOR, not supported
    prog.push_back(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd15, 4'd0, 8'h10));
    prog.push_back(dp_imm(OP_ADD, 1'b0, 4'd3, 4'd1, 4'd15, 8'hC3));
    run_program();
    // Dependency chain at distances 1 to 3
    prog.push_back(dp_imm(OP_ADD, 1'b0, 4'd1, 4'd1, 4'd0, 8'd1));
    prog.push_back(dp_reg(OP_ADD, 1'b0, 4'd1, 4'd2, 5'd0, 2'd0, 4'd1));
    prog.push_back(dp_reg(OP_SUB, 1'b0, 4'd2, 4'd3, 5'd0, 2'd0, 4'd1));
    prog.push_back(dp_reg(OP_ORR, 1'b0, 4'd1, 4'd4, 5'd3, 2'd0, 4'd3));
    prog.push_back(dp_reg(OP_AND, 1'b0, 4'd4, 4'd5, 5'd0, 2'd0, 4'd2));
    prog.push_back('0);
    prog.push_back(dp_reg(OP_ADD, 1'b0, 4'd5, 4'd6, 5'd0, 2'd0, 4'd4));
    prog.push_back(dp_reg(OP_ADD, 1'b0, 4'd6, 4'd6, 5'd1, 2'd0, 4'd6));
    run_program();
    // Shifter types and amounts, then R15 reads
    prog.push_back(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd9, 4'd4, 8'hF3));
    prog.push_back(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd8, 4'd0, 8'hA5));
    for (int t = 0; t < 4; t++) begin
      foreach (amts[j]) begin
        prog.push_back(dp_reg(OP_ADD, 1'b0, 4'd8, 4'd10, 5'(amts[j]), 2'(t), 4'd9));
      end
    end
    prog.push_back(dp_reg(OP_MOV, 1'b0, 4'd0, 4'd12, 5'd0, 2'd0, 4'd15));
    prog.push_back(dp_reg(OP_ADD, 1'b0, 4'd15, 4'd13, 5'd2, 2'd0, 4'd15));
    run_program();
    // Flag rules
    prog.push_back(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd1, 4'd4, 8'h7F));
    prog.push_back(dp_reg(OP_ADD, 1'b1, 4'd1, 4'd2, 5'd0, 2'd0, 4'd1));  // Signed overflow
    prog.push_back(dp_reg(OP_SUB, 1'b1, 4'd1, 4'd3, 5'd0, 2'd0, 4'd1));
    prog.push_back(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd5, 4'd0, 8'd1));
    prog.push_back(dp_imm(OP_SUB, 1'b1, 4'd5, 4'd6, 4'd0, 8'd2));  // Borrow
    prog.push_back(dp_imm(OP_MOV, 1'b0, 4'd0, 4'd7, 4'd4, 8'hFF));
    prog.push_back(dp_reg(OP_ADD, 1'b1, 4'd7, 4'd8, 5'd0, 2'd0, 4'd7));  // Carry out
    prog.push_back(dp_imm(OP_AND, 1'b1, 4'd1, 4'd9, 4'd0, 8'd0));
    prog.push_back(dp_imm(OP_ORR, 1'b1, 4'd5, 4'd9, 4'd1, 8'h02));
    prog.push_back(dp_imm(OP_MOV, 1'b1, 4'd0, 4'd10, 4'd0, 8'd0));
    prog.push_back(dp_imm(OP_ADD, 1'b0, 4'd7, 4'd11, 4'd0, 8'd1));  // Flags held
    prog.push_back(dp_reg(OP_SUB, 1'b1, 4'd7, 4'd12, 5'd0, 2'd0, 4'd1));
    run_program();
    // Random program
    for (int n = 0; n < 40; n++) begin
      rng = xorshift(rng);
      r1 = rng;
      rng = xorshift(rng);
      r2 = rng;
      prog.push_back({r1[31:28], 2'b00, r1[27], ops[r1[2:0] % 5], r1[26], r1[25:22],
                      r1[21:18], r2[11:0]});
    end
    run_program();
    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- arm_pipeline_top.sv
// Top level of the four-stage data-processing pipeline
`timescale 1ns/1ns

module arm_pipeline_top import arm_core_pkg::*, arm_isa_pkg::*; #(
  parameter int IMEM_BYTES = 256
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     prog_we,
  input  pc_t      prog_addr,
  input  word_t    prog_data,
  output pc_t      pc,
  output logic     wb_valid,
  output reg_idx_t wb_rd,
  output word_t    wb_data,
  output flags_t   flags
);

  instr_t   instr;
  reg_idx_t rn;
  reg_idx_t rm;
  word_t    rn_value;
  word_t    rm_value;

  dx_if     dx ();
  bypass_if byp ();

  fetch_counter #(.IMEM_BYTES(IMEM_BYTES)) u_fetch (
    .clk(clk), .reset(reset), .pc(pc)
  );

  instr_memory #(.IMEM_BYTES(IMEM_BYTES)) u_imem (
    .clk(clk), .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .addr(pc), .instr(instr)
  );

  register_file u_regs (
    .clk(clk), .rn(rn), .rm(rm), .pc(pc),
    .rn_value(rn_value), .rm_value(rm_value), .byp(byp.regfile)
  );

  decode_stage u_decode (
    .clk(clk), .reset(reset), .instr(instr), .pc(pc), .rn(rn), .rm(rm),
    .rn_value(rn_value), .rm_value(rm_value), .byp(byp.decode), .dx(dx.decode)
  );

  execute_stage u_execute (
    .clk(clk), .reset(reset), .dx(dx.execute), .byp(byp.execute), .flags(flags)
  );

  assign wb_valid = byp.wb_valid;
  assign wb_rd    = byp.wb_rd;
  assign wb_data  = byp.wb_data;

endmodule

//--- execute_stage.sv
// Operand-2 shifter, ALU, NZCV flag register and the EX/WB register
`timescale 1ns/1ns

module execute_stage import arm_core_pkg::*, arm_isa_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  dx_if.execute dx,
  bypass_if.execute byp,
  output flags_t flags
);

  logic [3:0]  rot;
  logic [7:0]  imm8;
  logic [4:0]  shamt;
  shift_type_e sh_type;
  word_t       shifted;
  word_t       op2;
  word_t       result;
  logic [32:0] sum;       // Carry out in bit 32
  logic        arith;     // ADD or SUB, C and V are live
  logic        overflow;
  flags_t      flags_next;

  assign rot     = dx.op2_field[ROT_HI:ROT_LO];
  assign imm8    = dx.op2_field[IMM_HI:IMM_LO];
  assign shamt   = dx.op2_field[SHAMT_HI:SHAMT_LO];
  assign sh_type = shift_type_e'(dx.op2_field[SHTYP_HI:SHTYP_LO]);

  function automatic word_t ror32(word_t value, logic [4:0] amount);
    logic [63:0] doubled;
    doubled = {value, value} >> amount;
    return doubled[31:0];
  endfunction

  // Register operand shift, amount 0 passes Rm through
  always_comb begin
    shifted = dx.op_m;
    if (shamt != 5'd0) begin
      case (sh_type)
        LSL:     shifted = dx.op_m << shamt;
        LSR:     shifted = dx.op_m >> shamt;
        ASR:     shifted = word_t'($signed(dx.op_m) >>> shamt);
        default: shifted = ror32(dx.op_m, shamt);
      endcase
    end
  end

  assign op2 = dx.imm_sel ? ror32({24'b0, imm8}, {rot, 1'b0}) : shifted;

  always_comb begin
    sum      = '0;
    arith    = 1'b0;
    overflow = 1'b0;
    result   = op2;  // MOV
    case (dx.alu_op)
      OP_AND: result = dx.op_a & op2;
      OP_ORR: result = dx.op_a | op2;
      OP_ADD: begin
        sum      = {1'b0, dx.op_a} + {1'b0, op2};
        arith    = 1'b1;
        result   = sum[31:0];
        overflow = (dx.op_a[31] == op2[31]) && (sum[31] != dx.op_a[31]);
      end
      OP_SUB: begin
        sum      = {1'b0, dx.op_a} + {1'b0, ~op2} + 33'd1;  // C set means no borrow
        arith    = 1'b1;
        result   = sum[31:0];
        overflow = (dx.op_a[31] != op2[31]) && (sum[31] != dx.op_a[31]);
      end
      default: result = op2;
    endcase
  end

  // Logic ops and MOV keep C and V
  always_comb begin
    flags_next         = flags;
    flags_next[FLAG_N] = result[31];
    flags_next[FLAG_Z] = (result == '0);
    if (arith) begin
      flags_next[FLAG_C] = sum[32];
      flags_next[FLAG_V] = overflow;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags <= '0;
    end else if (dx.valid && dx.set_flags) begin
      flags <= flags_next;
    end
  end

  assign byp.ex_valid  = dx.valid;
  assign byp.ex_rd     = dx.rd;
  assign byp.ex_result = result;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      byp.wb_valid <= 1'b0;
    end else begin
      byp.wb_valid <= dx.valid;  // One pulse per retired instruction
    end
  end

  always_ff @(posedge clk) begin
    byp.wb_rd   <= dx.rd;
    byp.wb_data <= result;
  end

endmodule

//--- decode_stage.sv
// IF/ID register, field decode, operand forwarding and the ID/EX register
`timescale 1ns/1ns

module decode_stage import arm_core_pkg::*, arm_isa_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  instr_t   instr,
  input  pc_t      pc,
  output reg_idx_t rn,
  output reg_idx_t rm,
  input  word_t    rn_value,
  input  word_t    rm_value,
  bypass_if.decode byp,
  dx_if.decode     dx
);

  instr_t     if_id;       // IF/ID register where zero is a bubble
  dp_opcode_e opcode;
  reg_idx_t   rd;
  logic       op_ok;
  logic       slot_valid;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      if_id <= '0;
    end else begin
      if_id <= instr;
    end
  end

  assign opcode = dp_opcode_e'(if_id[OPC_HI:OPC_LO]);
  assign rn     = if_id[RN_HI:RN_LO];
  assign rm     = if_id[RM_HI:RM_LO];
  assign rd     = if_id[RD_HI:RD_LO];

  always_comb begin
    case (opcode)
      OP_AND, OP_SUB, OP_ADD, OP_ORR, OP_MOV: op_ok = 1'b1;
      default:                                op_ok = 1'b0;
    endcase
  end

  // Cond bits ignored and writes to R15 dropped
  assign slot_valid = (if_id != '0) && op_ok && (rd != PC_REG);

  // EX result first, then WB, then the register file value
  function automatic word_t select_operand(reg_idx_t src, word_t rf_value);
    if (src == PC_REG) begin
      return rf_value;  // R15 is never forwarded
    end
    if (byp.ex_valid && (byp.ex_rd == src)) begin
      return byp.ex_result;
    end
    if (byp.wb_valid && (byp.wb_rd == src)) begin
      return byp.wb_data;
    end
    return rf_value;
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dx.valid <= 1'b0;
    end else begin
      dx.valid <= slot_valid;
    end
  end

  // Payload is only looked at while valid
  always_ff @(posedge clk) begin
    dx.alu_op    <= opcode;
    dx.set_flags <= if_id[S_BIT];
    dx.rd        <= rd;
    dx.op_a      <= select_operand(rn, rn_value);
    dx.op_m      <= select_operand(rm, rm_value);
    dx.imm_sel   <= if_id[I_BIT];
    dx.op2_field <= if_id[OP2_HI:OP2_LO];
  end

endmodule

//--- register_file.sv
// Fifteen general registers with a write decoder, two read ports and R15 as PC
`timescale 1ns/1ns

module register_file import arm_core_pkg::*; (
  input  logic     clk,
  input  reg_idx_t rn,
  input  reg_idx_t rm,
  input  pc_t      pc,
  output word_t    rn_value,
  output word_t    rm_value,
  bypass_if.regfile byp
);

  localparam int NUM_GPR = int'(PC_REG);  // R0..R14

  word_t              regs [NUM_GPR];
  logic [NUM_GPR-1:0] write_en;

  // One-hot write enable from the retiring Rd
  always_comb begin
    write_en = '0;
    if (byp.wb_valid && (byp.wb_rd != PC_REG)) begin
      write_en[byp.wb_rd] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_GPR; i++) begin
      if (write_en[i]) begin
        regs[i] <= byp.wb_data;
      end
    end
  end

  function automatic word_t read_port(reg_idx_t idx);
    if (idx == PC_REG) begin
      return word_t'(pc);  // Zero-extended
    end
    return regs[idx];
  endfunction

  assign rn_value = read_port(rn);
  assign rm_value = read_port(rm);

endmodule

//--- fetch_counter.sv
// Program counter register with a +4 increment that wraps at the memory size
`timescale 1ns/1ns

module fetch_counter import arm_core_pkg::*; #(
  parameter int IMEM_BYTES = 256
) (
  input  logic clk,
  input  logic reset,
  output pc_t  pc
);

  logic [8:0] pc_sum;  // One spare bit so 252 + 4 is seen

  assign pc_sum = {1'b0, pc} + 9'd4;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= '0;
    end else if (int'(pc_sum) >= IMEM_BYTES) begin
      pc <= '0;  // Wrap to the first word
    end else begin
      pc <= pc_sum[7:0];
    end
  end

endmodule

//--- instr_memory.sv
// Byte-wide instruction memory with a word program port and big-endian word read
`timescale 1ns/1ns

module instr_memory import arm_core_pkg::*, arm_isa_pkg::*; #(
  parameter int IMEM_BYTES = 256
) (
  input  logic   clk,
  input  logic   prog_we,
  input  pc_t    prog_addr,
  input  word_t  prog_data,
  input  pc_t    addr,
  output instr_t instr
);

  logic [7:0] mem [IMEM_BYTES] = '{default: 8'h00};  // Empty words decode as bubbles

  pc_t wr_base;
  pc_t rd_base;

  assign wr_base = {prog_addr[7:2], 2'b00};  // Word aligned
  assign rd_base = {addr[7:2], 2'b00};

  always_ff @(posedge clk) begin
    if (prog_we && (int'(wr_base) < IMEM_BYTES)) begin
      mem[wr_base]        <= prog_data[31:24];  // MSB at lowest address
      mem[wr_base + 8'd1] <= prog_data[23:16];
      mem[wr_base + 8'd2] <= prog_data[15:8];
      mem[wr_base + 8'd3] <= prog_data[7:0];
    end
  end

  assign instr = {mem[rd_base], mem[rd_base + 8'd1], mem[rd_base + 8'd2], mem[rd_base + 8'd3]};

endmodule

//--- pipe_ifs.sv
// Decode-to-execute bundle and the bypass/writeback bundle, with modports
`timescale 1ns/1ns

interface dx_if import arm_core_pkg::*, arm_isa_pkg::*; ();

  logic       valid;      // Slot holds a supported instruction
  dp_opcode_e alu_op;
  logic       set_flags;  // S bit
  reg_idx_t   rd;
  word_t      op_a;       // Rn after forwarding
  word_t      op_m;       // Rm after forwarding
  logic       imm_sel;    // I bit
  logic [11:0] op2_field;

  modport decode (
    output valid, alu_op, set_flags, rd, op_a, op_m, imm_sel, op2_field
  );

  modport execute (
    input valid, alu_op, set_flags, rd, op_a, op_m, imm_sel, op2_field
  );

endinterface

interface bypass_if import arm_core_pkg::*; ();

  logic     ex_valid;   // Combinational EX result
  reg_idx_t ex_rd;
  word_t    ex_result;
  logic     wb_valid;   // EX/WB register, also the write enable
  reg_idx_t wb_rd;
  word_t    wb_data;

  modport execute (output ex_valid, ex_rd, ex_result, wb_valid, wb_rd, wb_data);
  modport decode  (input ex_valid, ex_rd, ex_result, wb_valid, wb_rd, wb_data);
  modport regfile (input wb_valid, wb_rd, wb_data);

endinterface

//--- arm_isa_pkg.sv
// Data-processing instruction word, field positions, opcode and shift type enums
package arm_isa_pkg;

  typedef logic [31:0] instr_t;

  // Data-processing opcodes, ARM encodings
  typedef enum logic [3:0] {
    OP_AND = 4'b0000,
    OP_SUB = 4'b0010,
    OP_ADD = 4'b0100,
    OP_ORR = 4'b1100,
    OP_MOV = 4'b1101
  } dp_opcode_e;

  typedef enum logic [1:0] {
    LSL = 2'b00,
    LSR = 2'b01,
    ASR = 2'b10,
    ROR = 2'b11
  } shift_type_e;

  // Instruction word fields
  localparam int I_BIT    = 25;
  localparam int OPC_HI   = 24;
  localparam int OPC_LO   = 21;
  localparam int S_BIT    = 20;
  localparam int RN_HI    = 19;
  localparam int RN_LO    = 16;
  localparam int RD_HI    = 15;
  localparam int RD_LO    = 12;
  localparam int OP2_HI   = 11;
  localparam int OP2_LO   = 0;

  // Operand-2 sub-fields
  localparam int ROT_HI   = 11;
  localparam int ROT_LO   = 8;
  localparam int IMM_HI   = 7;
  localparam int IMM_LO   = 0;
  localparam int SHAMT_HI = 11;
  localparam int SHAMT_LO = 7;
  localparam int SHTYP_HI = 6;
  localparam int SHTYP_LO = 5;
  localparam int RM_HI    = 3;
  localparam int RM_LO    = 0;

endpackage

//--- arm_core_pkg.sv
// Datapath word, PC, register index and NZCV flag types for the core
package arm_core_pkg;

  typedef logic [31:0] word_t;     // Datapath word
  typedef logic [7:0]  pc_t;       // Byte address into instruction memory
  typedef logic [3:0]  reg_idx_t;  // Register number R0..R15
  typedef logic [3:0]  flags_t;    // N Z C V, N is the top bit

  localparam reg_idx_t PC_REG = 4'd15;  // R15 reads as the PC

  // Bit positions inside flags_t
  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

endpackage
